//--- common/soc_pkg.sv
package soc_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int LINE_W = 9;
    localparam int KEY_W  = 16;

    ////////////////////////////////////////
    // Bus and register selects
    ////////////////////////////////////////

    // One CPU bus cycle
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrdata;
        logic [3:0]  bytesel;
        logic        wren;
        logic        strobe;
    } bus_req_t;

    // One-hot, one bit per register
    typedef struct packed {
        logic mtime;
        logic mtimeh;
        logic mtimecmp;
        logic mtimecmph;
        logic keybuf;
        logic vctrl;
        logic vscrx;
        logic vscry;
        logic vline;
        logic virqline;
    } reg_sel_t;

    ////////////////////////////////////////
    // Video and audio payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic              sprites_enable;
        logic              gfx_tilemode;
        logic              gfx_enable;
        logic              text_priority;
        logic              text_mode80;
        logic              text_enable;
        logic [LINE_W-1:0] scroll_x;
        logic [7:0]        scroll_y;
        logic [LINE_W-1:0] irq_line;
    } video_ctrl_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } audio_sample_t;

    // Register map, word addresses
    localparam logic [31:0] REG_VCTRL     = 32'h0000_2008;
    localparam logic [31:0] REG_VSCRX     = 32'h0000_200C;
    localparam logic [31:0] REG_VSCRY     = 32'h0000_2010;
    localparam logic [31:0] REG_VLINE     = 32'h0000_2014;
    localparam logic [31:0] REG_VIRQLINE  = 32'h0000_2018;
    localparam logic [31:0] REG_KEYBUF    = 32'h0000_201C;
    localparam logic [31:0] REG_MTIME     = 32'h0000_2080;
    localparam logic [31:0] REG_MTIMEH    = 32'h0000_2084;
    localparam logic [31:0] REG_MTIMECMP  = 32'h0000_2088;
    localparam logic [31:0] REG_MTIMECMPH = 32'h0000_208C;

    // Interrupt vector bit positions
    localparam int IRQ_KEYBUF = 19;
    localparam int IRQ_LINE   = 17;
    localparam int IRQ_VBLANK = 16;
    localparam int IRQ_TIMER  = 7;

endpackage

//--- logic/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder
    import soc_pkg::*;
(
    input  bus_req_t          bus,
    output reg_sel_t          wr_sel,
    output reg_sel_t          rd_sel,
    input  logic [63:0]       mtime,
    input  logic [63:0]       mtimecmp,
    input  logic [KEY_W-1:0]  key_head,
    input  logic              key_empty,
    input  video_ctrl_t       vctrl,
    input  logic [LINE_W-1:0] vline,
    output logic [31:0]       rddata
);

    logic [31:0] word_addr;
    reg_sel_t    hit;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Byte offset within the word is ignored
    assign word_addr = {bus.addr[31:2], 2'b00};

    always_comb begin
        hit = '0;
        case (word_addr)
            REG_MTIME:     hit.mtime     = 1'b1;
            REG_MTIMEH:    hit.mtimeh    = 1'b1;
            REG_MTIMECMP:  hit.mtimecmp  = 1'b1;
            REG_MTIMECMPH: hit.mtimecmph = 1'b1;
            REG_KEYBUF:    hit.keybuf    = 1'b1;
            REG_VCTRL:     hit.vctrl     = 1'b1;
            REG_VSCRX:     hit.vscrx     = 1'b1;
            REG_VSCRY:     hit.vscry     = 1'b1;
            REG_VLINE:     hit.vline     = 1'b1;
            REG_VIRQLINE:  hit.virqline  = 1'b1;
            default: ;
        endcase
    end

    // Write and read selects
    always_comb begin
        wr_sel = '0;
        rd_sel = '0;
        if (bus.strobe) begin
            if (bus.wren) begin
                wr_sel = hit;
            end else begin
                rd_sel = hit;
            end
        end
    end

    ////////////////////////////////////////
    // Read data mux
    ////////////////////////////////////////

    // Unmapped addresses fall through to zero
    always_comb begin
        rddata = '0;
        if (rd_sel.mtime) begin
            rddata = mtime[31:0];
        end
        if (rd_sel.mtimeh) begin
            rddata = mtime[63:32];
        end
        if (rd_sel.mtimecmp) begin
            rddata = mtimecmp[31:0];
        end
        if (rd_sel.mtimecmph) begin
            rddata = mtimecmp[63:32];
        end
        if (rd_sel.keybuf) begin
            // Empty flag on top, head entry below
            rddata = {key_empty, {(31 - KEY_W){1'b0}}, key_head};
        end
        if (rd_sel.vctrl) begin
            rddata = {
                26'b0,
                vctrl.sprites_enable,
                vctrl.gfx_tilemode,
                vctrl.gfx_enable,
                vctrl.text_priority,
                vctrl.text_mode80,
                vctrl.text_enable
            };
        end
        if (rd_sel.vscrx) begin
            rddata = {{(32 - LINE_W){1'b0}}, vctrl.scroll_x};
        end
        if (rd_sel.vscry) begin
            rddata = {24'b0, vctrl.scroll_y};
        end
        if (rd_sel.vline) begin
            rddata = {{(32 - LINE_W){1'b0}}, vline};
        end
        if (rd_sel.virqline) begin
            rddata = {{(32 - LINE_W){1'b0}}, vctrl.irq_line};
        end
    end

endmodule

//--- logic/machine_timer.sv
`timescale 1ns/100ps

module machine_timer
    import soc_pkg::*;
#(
    parameter int TICK_DIV = 25175
) (
    input  logic        clk,
    input  logic        reset,
    input  reg_sel_t    wr_sel,
    input  logic [31:0] wrdata,
    output logic [63:0] mtime,
    output logic [63:0] mtimecmp,
    output logic        timer_irq
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;
    logic [63:0]      mtime_next;

    ////////////////////////////////////////
    // Tick divider
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= RELOAD;
            tick     <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (tick_cnt == '0) begin
                tick_cnt <= RELOAD;
                tick     <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Time and compare
    ////////////////////////////////////////

    // Bus write to a half wins over the increment of that half
    always_comb begin
        mtime_next = tick ? mtime + 64'd1 : mtime;
        if (wr_sel.mtime) begin
            mtime_next[31:0] = wrdata;
        end
        if (wr_sel.mtimeh) begin
            mtime_next[63:32] = wrdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtime     <= '0;
            mtimecmp  <= '0;
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime_next;
            timer_irq <= (mtimecmp <= mtime);
            if (wr_sel.mtimecmp) begin
                mtimecmp[31:0] <= wrdata;
            end
            if (wr_sel.mtimecmph) begin
                mtimecmp[63:32] <= wrdata;
            end
        end
    end

endmodule

//--- logic/key_fifo.sv
`timescale 1ns/100ps

module key_fifo
    import soc_pkg::*;
#(
    parameter int KEY_DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             key_wr,
    input  logic [KEY_W-1:0] key_data,
    input  reg_sel_t         rd_sel,
    input  reg_sel_t         wr_sel,
    output logic [KEY_W-1:0] key_head,
    output logic             key_empty
);

    localparam int AW = (KEY_DEPTH > 1) ? $clog2(KEY_DEPTH) : 1;

    logic [KEY_W-1:0] mem [KEY_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             full;
    logic             push;
    logic             pop;

    assign full      = (count == (AW + 1)'(KEY_DEPTH));
    assign key_empty = (count == '0);
    assign key_head  = mem[rd_ptr];

    // Full buffer drops the key, empty buffer ignores the pop
    assign push = key_wr && !full;
    assign pop  = rd_sel.keybuf && !key_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= key_data;
        end
    end

    ////////////////////////////////////////
    // Pointers and fill count
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (wr_sel.keybuf) begin
            // Bus write flushes everything
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/video_regs.sv
`timescale 1ns/100ps

module video_regs
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  reg_sel_t    wr_sel,
    input  logic [31:0] wrdata,
    output video_ctrl_t vctrl
);

    ////////////////////////////////////////
    // Video control registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl <= '0;
        end else begin
            if (wr_sel.vctrl) begin
                // Six enable and mode bits
                vctrl.sprites_enable <= wrdata[5];
                vctrl.gfx_tilemode   <= wrdata[4];
                vctrl.gfx_enable     <= wrdata[3];
                vctrl.text_priority  <= wrdata[2];
                vctrl.text_mode80    <= wrdata[1];
                vctrl.text_enable    <= wrdata[0];
            end

            if (wr_sel.vscrx) begin
                vctrl.scroll_x <= wrdata[LINE_W-1:0];
            end

            if (wr_sel.vscry) begin
                vctrl.scroll_y <= wrdata[7:0];
            end

            // Own address only, not shared with scroll Y
            if (wr_sel.virqline) begin
                vctrl.irq_line <= wrdata[LINE_W-1:0];
            end
        end
    end

endmodule

//--- logic/audio_mix.sv
`timescale 1ns/100ps

module audio_mix
    import soc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  audio_sample_t src_a,
    input  audio_sample_t src_b,
    output audio_sample_t audio_out
);

    // Add with one guard bit, clamp on overflow
    function automatic logic [15:0] sat_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] sum;
        sum = {a[15], a} + {b[15], b};
        case (sum[16:15])
            2'b01:   return 16'h7FFF;
            2'b10:   return 16'h8000;
            default: return sum[15:0];
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            audio_out <= '0;
        end else begin
            audio_out.left  <= sat_add(src_a.left, src_b.left);
            audio_out.right <= sat_add(src_a.right, src_b.right);
        end
    end

endmodule

//--- logic/periph_top.sv
`timescale 1ns/100ps

module periph_top
    import soc_pkg::*;
#(
    parameter int TICK_DIV  = 25175,
    parameter int KEY_DEPTH = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  bus_req_t          bus,
    output logic [31:0]       rddata,
    input  logic              key_wr,
    input  logic [KEY_W-1:0]  key_data,
    input  logic [LINE_W-1:0] vline,
    input  logic              irq_line,
    input  logic              irq_vblank,
    input  audio_sample_t     src_a,
    input  audio_sample_t     src_b,
    output video_ctrl_t       vctrl,
    output audio_sample_t     audio_out,
    output logic [31:0]       irq
);

    reg_sel_t         wr_sel;
    reg_sel_t         rd_sel;
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic             timer_irq;
    logic [KEY_W-1:0] key_head;
    logic             key_empty;

    ////////////////////////////////////////
    // Register blocks
    ////////////////////////////////////////
    bus_decoder bus_decoder_i (
        .bus       (bus),
        .wr_sel    (wr_sel),
        .rd_sel    (rd_sel),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .key_head  (key_head),
        .key_empty (key_empty),
        .vctrl     (vctrl),
        .vline     (vline),
        .rddata    (rddata)
    );

    machine_timer #(
        .TICK_DIV (TICK_DIV)
    ) machine_timer_i (
        .clk       (clk),
        .reset     (reset),
        .wr_sel    (wr_sel),
        .wrdata    (bus.wrdata),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

    key_fifo #(
        .KEY_DEPTH (KEY_DEPTH)
    ) key_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .key_wr    (key_wr),
        .key_data  (key_data),
        .rd_sel    (rd_sel),
        .wr_sel    (wr_sel),
        .key_head  (key_head),
        .key_empty (key_empty)
    );

    video_regs video_regs_i (
        .clk    (clk),
        .reset  (reset),
        .wr_sel (wr_sel),
        .wrdata (bus.wrdata),
        .vctrl  (vctrl)
    );

    audio_mix audio_mix_i (
        .clk       (clk),
        .reset     (reset),
        .src_a     (src_a),
        .src_b     (src_b),
        .audio_out (audio_out)
    );

    ////////////////////////////////////////
    // Interrupt vector
    ////////////////////////////////////////

    // Only the timer bit comes from a flop
    always_comb begin
        irq             = '0;
        irq[IRQ_KEYBUF] = !key_empty;
        irq[IRQ_LINE]   = irq_line;
        irq[IRQ_VBLANK] = irq_vblank;
        irq[IRQ_TIMER]  = timer_irq;
    end

endmodule

//--- tb/periph_ref.svh
`ifndef PERIPH_REF_SVH
`define PERIPH_REF_SVH

// Model state, updated by the stimulus as it drives the bus
logic [5:0]        m_ctrl  = '0;
logic [LINE_W-1:0] m_scrx  = '0;
logic [7:0]        m_scry  = '0;
logic [LINE_W-1:0] m_irql  = '0;
logic [LINE_W-1:0] m_vline = '0;
logic [63:0]       m_cmp   = '0;
logic              m_timer = 1'b1;
logic [KEY_W-1:0]  key_q[$];

////////////////////////////////////////
// Register model
////////////////////////////////////////
function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
        REG_VCTRL:     m_ctrl = data[5:0];
        REG_VSCRX:     m_scrx = data[LINE_W-1:0];
        REG_VSCRY:     m_scry = data[7:0];
        REG_VIRQLINE:  m_irql = data[LINE_W-1:0];
        REG_KEYBUF:    key_q.delete();
        REG_MTIMECMP:  m_cmp[31:0] = data;
        REG_MTIMECMPH: m_cmp[63:32] = data;
        default: ;
    endcase
endfunction

// Keys beyond the buffer depth are lost
function automatic void model_push(input logic [KEY_W-1:0] key);
    if (key_q.size() < KEY_DEPTH) begin
        key_q.push_back(key);
    end
endfunction

// Low bits of an empty keybuf read are stale, only bit 31 is defined
function automatic logic [31:0] expected_read(input logic [31:0] addr);
    case (addr)
        REG_VCTRL:     return {26'b0, m_ctrl};
        REG_VSCRX:     return 32'(m_scrx);
        REG_VSCRY:     return 32'(m_scry);
        REG_VIRQLINE:  return 32'(m_irql);
        REG_VLINE:     return 32'(m_vline);
        REG_MTIMECMP:  return m_cmp[31:0];
        REG_MTIMECMPH: return m_cmp[63:32];
        REG_KEYBUF:    return (key_q.size() == 0) ? 32'h8000_0000 : 32'(key_q[0]);
        default:       return 32'h0;
    endcase
endfunction

function automatic video_ctrl_t expected_vctrl();
    return {m_ctrl, m_scrx, m_scry, m_irql};
endfunction

////////////////////////////////////////
// Audio and interrupts
////////////////////////////////////////
function automatic logic [15:0] sat_mix(input logic signed [15:0] a,
                                        input logic signed [15:0] b);
    int sum;
    sum = int'(a) + int'(b);
    if (sum > 32767) begin
        return 16'h7FFF;
    end else if (sum < -32768) begin
        return 16'h8000;
    end
    return sum[15:0];
endfunction

function automatic audio_sample_t mix_expected(input audio_sample_t a, input audio_sample_t b);
    audio_sample_t r;
    r.left  = sat_mix(a.left, b.left);
    r.right = sat_mix(a.right, b.right);
    return r;
endfunction

function automatic logic [31:0] irq_expected(input logic keys, input logic line,
                                             input logic vblank, input logic timer);
    logic [31:0] v;
    v             = '0;
    v[IRQ_KEYBUF] = keys;
    v[IRQ_LINE]   = line;
    v[IRQ_VBLANK] = vblank;
    v[IRQ_TIMER]  = timer;
    return v;
endfunction

`endif

//--- tb/periph_tb.sv
`timescale 1ns/100ps

module periph_tb
    import soc_pkg::*;
();

    localparam int TICK_DIV  = 8;
    localparam int KEY_DEPTH = 16;
    localparam int TICK_N    = 20;
    // Whole run is about 500 cycles, the longest part being the tick wait
    localparam int MAX_CYCLES = 4000;
    // Audio corner values 0x7FFF, 0x8000, 0x0001 and 0xFFFF
    localparam logic [63:0] EDGES = 64'h7FFF_8000_0001_FFFF;

    logic              clk;
    logic              reset;
    bus_req_t          bus;
    logic [31:0]       rddata;
    logic              key_wr;
    logic [KEY_W-1:0]  key_data;
    logic [LINE_W-1:0] vline;
    logic              irq_line;
    logic              irq_vblank;
    audio_sample_t     src_a;
    audio_sample_t     src_b;
    video_ctrl_t       vctrl;
    audio_sample_t     audio_out;
    logic [31:0]       irq;

    logic [31:0] seed = 32'd75887;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       name_q[$];
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    string       cmp_name;

    `include "periph_ref.svh"

    periph_top #(.TICK_DIV(TICK_DIV), .KEY_DEPTH(KEY_DEPTH)) periph_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////
    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            cmp_name = name_q.pop_front();
            checks++;
            if (cmp_act !== cmp_exp) begin
                $display("ERR %s expected %h got %h", cmp_name, cmp_exp, cmp_act);
                errors++;
                test_errors++;
            end
        end
    end

    task automatic queue_check(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
        name_q.push_back(name);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        checks++;
        errors++;
        test_errors++;
    endtask

    // Halves swapped since the low LCG bits repeat quickly
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    ////////////////////////////////////////
    // Bus and key port
    ////////////////////////////////////////
    task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] data, input logic wr,
                             output logic [31:0] rd);
        @(posedge clk);
        bus <= {addr, data, 4'hF, wr, 1'b1};
        @(negedge clk);
        rd = rddata;
        @(posedge clk);
        bus <= '0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(addr, data, 1'b1, unused);
        model_write(addr, data);
    endtask

    task automatic check_read(input logic [31:0] addr);
        logic [31:0] rd;
        bus_cycle(addr, 32'h0, 1'b0, rd);
        queue_check($sformatf("rddata@%h", addr), expected_read(addr), rd);
    endtask

    task automatic push_key(input logic [KEY_W-1:0] key);
        @(posedge clk);
        key_wr   <= 1'b1;
        key_data <= key;
        @(posedge clk);
        key_wr   <= 1'b0;
        model_push(key);
    endtask

    // Pop in order until empty, then one read must flag empty
    task automatic drain_keys();
        logic [31:0] rd;
        while (key_q.size() > 0) begin
            check_read(REG_KEYBUF);
            void'(key_q.pop_front());
            @(negedge clk);
            queue_check("irq[19]", 32'(key_q.size() != 0), 32'(irq[IRQ_KEYBUF]));
        end
        bus_cycle(REG_KEYBUF, 32'h0, 1'b0, rd);
        queue_check("rddata[31]", 32'h1, 32'(rd[31]));
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #1;
        tests++;
        $display("%s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        logic [31:0]   r;
        audio_sample_t a;
        audio_sample_t b;
        reset      = 1'b1;
        bus        = '0;
        key_wr     = 1'b0;
        key_data   = '0;
        vline      = '0;
        irq_line   = 1'b0;
        irq_vblank = 1'b0;
        src_a      = '0;
        src_b      = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        repeat (3) begin
            write_reg(REG_VCTRL, lcg_next());
            write_reg(REG_VSCRX, lcg_next());
            write_reg(REG_VSCRY, lcg_next());
            write_reg(REG_VIRQLINE, lcg_next());
            r = lcg_next();
            vline   <= r[LINE_W-1:0];
            m_vline = r[LINE_W-1:0];
            check_read(REG_VCTRL);
            check_read(REG_VSCRX);
            check_read(REG_VSCRY);
            check_read(REG_VIRQLINE);
            check_read(REG_VLINE);
            check_read(32'h0000_2020);
            check_read(32'h0001_2008);
            @(negedge clk);
            queue_check("vctrl", expected_vctrl(), vctrl);
        end
        end_test("video");

        // Tick phase is free running, so allow one tick either way
        write_reg(REG_MTIMEH, 32'h0);
        write_reg(REG_MTIME, 32'h0);
        repeat (TICK_DIV * TICK_N) @(posedge clk);
        bus_cycle(REG_MTIME, 32'h0, 1'b0, r);
        if (r < TICK_N - 1 || r > TICK_N + 1) begin
            report_failure($sformatf("ERR rddata@%h expected %h to %h got %h",
                                     REG_MTIME, 32'(TICK_N - 1), 32'(TICK_N + 1), r));
        end
        end_test("tick");

        write_reg(REG_MTIMECMPH, 32'hFFFF_0000);
        m_timer = 1'b0;
        @(posedge clk);
        @(negedge clk);
        queue_check("irq[7]", 32'(m_timer), 32'(irq[IRQ_TIMER]));
        check_read(REG_MTIMECMPH);
        bus_cycle(REG_MTIME, 32'h0, 1'b0, r);
        write_reg(REG_MTIMECMP, r + 32'd3);
        write_reg(REG_MTIMECMPH, 32'h0);
        m_timer = 1'b1;
        repeat (40) @(posedge clk);
        @(negedge clk);
        queue_check("irq[7]", 32'(m_timer), 32'(irq[IRQ_TIMER]));
        check_read(REG_MTIMECMP);
        end_test("timer");

        repeat (5) begin
            r = lcg_next();
            push_key(r[KEY_W-1:0]);
        end
        drain_keys();
        // Overfill so that the last four are dropped
        repeat (KEY_DEPTH + 4) begin
            r = lcg_next();
            push_key(r[KEY_W-1:0]);
        end
        drain_keys();
        repeat (3) begin
            r = lcg_next();
            push_key(r[KEY_W-1:0]);
        end
        write_reg(REG_KEYBUF, 32'h0);
        drain_keys();
        end_test("keybuf");

        for (int i = 0; i < 32; i++) begin
            if (i < 16) begin
                a = {EDGES[16*(i%4) +: 16], EDGES[16*(i/4) +: 16]};
                b = {EDGES[16*(i/4) +: 16], EDGES[16*(i%4) +: 16]};
            end else begin
                a = lcg_next();
                b = lcg_next();
            end
            @(posedge clk);
            src_a <= a;
            src_b <= b;
            @(posedge clk);
            @(negedge clk);
            queue_check("audio_out", mix_expected(a, b), audio_out);
        end
        end_test("audio");

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            irq_line   <= i[0];
            irq_vblank <= i[1];
            @(negedge clk);
            queue_check("irq", irq_expected(key_q.size() != 0, i[0], i[1], m_timer), irq);
        end
        end_test("irq");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+tb
common/soc_pkg.sv
logic/bus_decoder.sv
logic/machine_timer.sv
logic/key_fifo.sv
logic/video_regs.sv
logic/audio_mix.sv
logic/periph_top.sv
tb/periph_tb.sv
